//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f verilog.f \
        --top-module tb_ecc_dsa_ctrl -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vtb_ecc_dsa_ctrl)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- sim/tb_ecc_dsa_ctrl.sv
`default_nettype none

module tb_ecc_dsa_ctrl;
    import dsa_ctrl_pkg::*;

    localparam int READY_TIMEOUT = 200;
    localparam int RUN_TIMEOUT   = 400;
    localparam int ROUNDS        = 8;

    logic     clk;
    logic     reset_n;
    dsa_cmd_t cmd_i;
    word_t    msg_i;
    word_t    privkey_i;
    word_t    r_i;
    word_t    s_i;
    word_t    pubkey_o;
    word_t    sign_s_o;
    word_t    verify_o;
    logic     ready_o;
    logic     valid_o;
    integer   seed;

    ecc_dsa_ctrl ecc_dsa_ctrl_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .cmd_i     (cmd_i),
        .msg_i     (msg_i),
        .privkey_i (privkey_i),
        .r_i       (r_i),
        .s_i       (s_i),
        .pubkey_o  (pubkey_o),
        .sign_s_o  (sign_s_o),
        .verify_o  (verify_o),
        .ready_o   (ready_o),
        .valid_o   (valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------
    task automatic value_mismatch(input string what, input word_t got, input word_t exp);
        $display("FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic protocol_error(input string what);
        $display("FAILED at time %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic timeout_abort(input string what);
        $display("Timeout at time %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "stopping after a timeout");
    endtask

    // reference model in 64-bit arithmetic mod P
    function automatic word_t mul_mod(input word_t a, input word_t b);
        logic [63:0] p;
        p = {32'd0, a} * {32'd0, b};
        return word_t'(p % {32'd0, PRIME});
    endfunction

    function automatic word_t add_mod(input word_t a, input word_t b);
        logic [63:0] s;
        s = ({32'd0, a} + {32'd0, b}) % {32'd0, PRIME};
        return word_t'(s);
    endfunction

    function automatic word_t sub_mod(input word_t a, input word_t b);
        logic [63:0] d;
        d = ({32'd0, a} + {32'd0, PRIME} - {32'd0, b}) % {32'd0, PRIME};
        return word_t'(d);
    endfunction

    task automatic random_operand(output word_t v);
        v = $random(seed);
        if (v >= PRIME) v = v - PRIME;
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else value_mismatch(what, got, exp);
    endtask

    // the end of a program raises valid and ready together
    valid_with_ready: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(valid_o) |-> ready_o)
        else protocol_error("valid_o rose while ready_o was low");

    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        while (!ready_o) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > READY_TIMEOUT) timeout_abort({"ready_o never rose before ", name});
        end
    endtask

    // ------------------------------------------------------------
    // one command from the pulse to the end of its program
    // ------------------------------------------------------------
    task automatic run_command(input dsa_cmd_t cmd, input string name);
        int   cycles;
        logic saw_valid_low;
        wait_ready(name);
        cmd_i = cmd;
        @(posedge clk);
        #1;
        cmd_i = CMD_NONE;
        assert (!ready_o) else protocol_error({"ready_o still high after ", name, " pulse"});
        saw_valid_low = 1'b0;
        cycles = 0;
        while (!ready_o) begin
            if (saw_valid_low) begin
                assert (!valid_o) else protocol_error({"valid_o rose early in ", name});
            end
            if (!valid_o) saw_valid_low = 1'b1;
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > RUN_TIMEOUT) timeout_abort({name, " program did not finish"});
        end
        assert (saw_valid_low) else protocol_error({"valid_o never dropped during ", name});
        assert (valid_o) else protocol_error({"valid_o low at the end of ", name});
    endtask

    task automatic run_round(input word_t msg, input word_t priv, input word_t r);
        word_t exp_pub;
        word_t exp_s;
        word_t s_sig;
        word_t s_bad;
        msg_i     = msg;
        privkey_i = priv;
        r_i       = r;
        s_i       = '0;
        exp_pub   = mul_mod(priv, GEN_CONST);
        exp_s     = add_mod(msg, mul_mod(r, priv));

        run_command(CMD_KEYGEN, "keygen");
        check_word("keygen pubkey_o", pubkey_o, exp_pub);

        run_command(CMD_SIGN, "sign");
        check_word("sign sign_s_o", sign_s_o, exp_s);
        s_sig = sign_s_o;

        // a genuine signature gives back the message
        s_i = s_sig;
        run_command(CMD_VERIFY, "verify");
        check_word("verify verify_o", verify_o, msg);

        s_bad = add_mod(exp_s, 32'd1);
        s_i   = s_bad;
        run_command(CMD_VERIFY, "tampered verify");
        check_word("tampered verify_o", verify_o, sub_mod(s_bad, mul_mod(r, priv)));
    endtask

    initial begin
        int    cycles;
        word_t m;
        word_t k;
        word_t r;
        seed      = 32'hf883;
        reset_n   = 1'b0;
        cmd_i     = CMD_NONE;
        msg_i     = '0;
        privkey_i = '0;
        r_i       = '0;
        s_i       = '0;
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // reset program runs with valid low
        cycles = 0;
        while (!ready_o) begin
            assert (!valid_o) else protocol_error("valid_o high during the reset program");
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > READY_TIMEOUT) timeout_abort("ready_o did not rise after reset");
        end
        assert (!valid_o) else protocol_error("valid_o high after reset");

        run_round(32'd12345, 32'd1, 32'd2);
        run_round(PRIME - 32'd1, PRIME - 32'd1, PRIME - 32'd2);
        run_round(32'd0, PRIME - 32'd1, 32'd1);

        for (int i = 0; i < ROUNDS; i++) begin
            random_operand(m);
            random_operand(k);
            random_operand(r);
            run_round(m, k, r);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/dsa_ctrl_pkg.sv
`default_nettype none

package dsa_ctrl_pkg;

    // operand words
    localparam int DATA_W = 32;
    typedef logic [DATA_W-1:0] word_t;

    localparam word_t PRIME     = 32'hFFFFFFFB;
    localparam word_t GEN_CONST = 32'd7;

    // microcode addressing
    localparam int PROG_ADDR_W = 6;
    typedef logic [PROG_ADDR_W-1:0] prog_addr_t;

    // ------------------------------------------------------------
    // microcode line, from the top: uop, arith cmd, reg id, slot
    // ------------------------------------------------------------
    localparam int UOP_W   = 2;
    localparam int CMD_W   = 2;
    localparam int ID_W    = 4;
    localparam int SLOT_W  = 3;
    localparam int INSTR_W = UOP_W + CMD_W + ID_W + SLOT_W;
    typedef logic [INSTR_W-1:0] instr_t;

    localparam int SLOT_LSB = 0;
    localparam int ID_LSB   = SLOT_LSB + SLOT_W;
    localparam int CMD_LSB  = ID_LSB + ID_W;
    localparam int UOP_LSB  = CMD_LSB + CMD_W;

    typedef enum logic [UOP_W-1:0] {
        UOP_NOP,
        UOP_WR_CORE,
        UOP_RD_CORE
    } uop_t;

    // every operation computes slot 2 from slots 0 and 1
    typedef enum logic [CMD_W-1:0] {
        ARITH_NONE,
        ARITH_ADD,
        ARITH_SUB,
        ARITH_MUL
    } arith_cmd_t;

    typedef logic [ID_W-1:0] reg_id_t;
    localparam reg_id_t ID_ZERO    = 4'd0;
    localparam reg_id_t ID_GEN     = 4'd1;
    localparam reg_id_t ID_MSG     = 4'd2;
    localparam reg_id_t ID_PRIVKEY = 4'd3;
    localparam reg_id_t ID_R       = 4'd4;
    localparam reg_id_t ID_S       = 4'd5;
    localparam reg_id_t ID_TMP     = 4'd6;
    localparam reg_id_t ID_PUBKEY  = 4'd7;
    localparam reg_id_t ID_SIGN_S  = 4'd8;
    localparam reg_id_t ID_VERIFY  = 4'd9;

    typedef enum logic [1:0] {
        CMD_NONE,
        CMD_KEYGEN,
        CMD_SIGN,
        CMD_VERIFY
    } dsa_cmd_t;

    // program entry and exit points
    localparam prog_addr_t DSA_RESET = 6'd0;
    localparam prog_addr_t DSA_NOP   = 6'd3;
    localparam prog_addr_t DSA_KG_S  = 6'd4;
    localparam prog_addr_t DSA_KG_E  = 6'd7;
    localparam prog_addr_t DSA_SGN_S = 6'd8;
    localparam prog_addr_t DSA_SGN_E = 6'd14;
    localparam prog_addr_t DSA_VER_S = 6'd15;
    localparam prog_addr_t DSA_VER_E = 6'd21;

    localparam int STEP_CYCLES = 4;

    typedef enum logic [1:0] {
        ST_BOOT,
        ST_IDLE,
        ST_PEND,
        ST_RUN
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- src/dsa_operand_router.sv
`default_nettype none

module dsa_operand_router (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        ready_i,
    input  wire dsa_ctrl_pkg::instr_t  line_i,
    input  wire dsa_ctrl_pkg::word_t   msg_i,
    input  wire dsa_ctrl_pkg::word_t   privkey_i,
    input  wire dsa_ctrl_pkg::word_t   r_i,
    input  wire dsa_ctrl_pkg::word_t   s_i,
    input  wire dsa_ctrl_pkg::word_t   read_data_i,
    output dsa_ctrl_pkg::word_t        write_data_o,
    output dsa_ctrl_pkg::word_t        pubkey_o,
    output dsa_ctrl_pkg::word_t        sign_s_o,
    output dsa_ctrl_pkg::word_t        verify_o
);
    import dsa_ctrl_pkg::*;

    word_t   msg_reg;
    word_t   privkey_reg;
    word_t   r_reg;
    word_t   s_reg;
    word_t   tmp_reg;
    uop_t    uop;
    reg_id_t reg_id;
    logic    tmp_we;
    logic    pubkey_we;
    logic    sign_s_we;
    logic    verify_we;

    assign uop    = uop_t'(line_i[UOP_LSB +: UOP_W]);
    assign reg_id = line_i[ID_LSB +: ID_W];

    // operand select toward the engine
    always_comb begin
        write_data_o = '0;
        if (uop == UOP_WR_CORE) begin
            case (reg_id)
                ID_GEN:     write_data_o = GEN_CONST;
                ID_MSG:     write_data_o = msg_reg;
                ID_PRIVKEY: write_data_o = privkey_reg;
                ID_R:       write_data_o = r_reg;
                ID_S:       write_data_o = s_reg;
                ID_TMP:     write_data_o = tmp_reg;
                default:    write_data_o = '0;
            endcase
        end
    end

    // result register write enables
    always_comb begin
        tmp_we    = 1'b0;
        pubkey_we = 1'b0;
        sign_s_we = 1'b0;
        verify_we = 1'b0;
        if (uop == UOP_RD_CORE) begin
            case (reg_id)
                ID_TMP:    tmp_we    = 1'b1;
                ID_PUBKEY: pubkey_we = 1'b1;
                ID_SIGN_S: sign_s_we = 1'b1;
                ID_VERIFY: verify_we = 1'b1;
                default:   ;
            endcase
        end
    end

    // inputs follow the ports until a command is taken
    always_ff @(posedge clk) begin
        if (ready_i) begin
            msg_reg     <= msg_i;
            privkey_reg <= privkey_i;
            r_reg       <= r_i;
            s_reg       <= s_i;
        end
        if (tmp_we) begin
            tmp_reg <= read_data_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pubkey_o <= '0;
            sign_s_o <= '0;
            verify_o <= '0;
        end else begin
            if (pubkey_we) pubkey_o <= read_data_i;
            if (sign_s_we) sign_s_o <= read_data_i;
            if (verify_we) verify_o <= read_data_i;
        end
    end

    // captured operands must already be reduced
    a_operand_reduced: assert property (@(posedge clk) disable iff (!reset_n)
        (uop == UOP_WR_CORE) |-> (write_data_o < PRIME));

endmodule

`default_nettype wire

//--- src/dsa_prog_ctrl.sv
`default_nettype none

module dsa_prog_ctrl (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire dsa_ctrl_pkg::dsa_cmd_t   cmd_i,
    input  wire dsa_ctrl_pkg::instr_t     line_i,
    input  wire                           arith_busy_i,
    output dsa_ctrl_pkg::prog_addr_t      prog_cntr_o,
    output dsa_ctrl_pkg::arith_cmd_t      arith_cmd_o,
    output logic                          ready_o,
    output logic                          valid_o
);
    import dsa_ctrl_pkg::*;

    localparam int STEP_W = $clog2(STEP_CYCLES);

    ctrl_state_t       state;
    dsa_cmd_t          cmd_reg;
    logic [STEP_W-1:0] step_cnt;
    logic              step;

    assign step    = (step_cnt == STEP_W'(STEP_CYCLES - 1)) && !arith_busy_i;
    assign ready_o = (state == ST_IDLE);

    // step pacing, parked on the last cycle while the engine is busy
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            step_cnt <= '0;
        end else if (arith_busy_i) begin
            step_cnt <= STEP_W'(STEP_CYCLES - 1);
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // program counter FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= ST_BOOT;
            cmd_reg     <= CMD_NONE;
            prog_cntr_o <= DSA_RESET;
            arith_cmd_o <= ARITH_NONE;
            valid_o     <= 1'b0;
        end else begin
            arith_cmd_o <= ARITH_NONE;

            if (state == ST_IDLE && cmd_i != CMD_NONE) begin
                cmd_reg <= cmd_i;
                state   <= ST_PEND;
            end

            if (step) begin
                case (prog_cntr_o)
                    DSA_NOP: begin
                        if (state == ST_BOOT) begin
                            state <= ST_IDLE;
                        end else if (state == ST_PEND) begin
                            state <= ST_RUN;
                            case (cmd_reg)
                                CMD_KEYGEN: prog_cntr_o <= DSA_KG_S;
                                CMD_SIGN:   prog_cntr_o <= DSA_SGN_S;
                                default:    prog_cntr_o <= DSA_VER_S;
                            endcase
                        end
                    end
                    DSA_KG_E, DSA_SGN_E, DSA_VER_E: begin
                        prog_cntr_o <= DSA_NOP;
                        state       <= ST_IDLE;
                        valid_o     <= 1'b1;
                    end
                    default: begin
                        if (prog_cntr_o inside {DSA_KG_S, DSA_SGN_S, DSA_VER_S}) begin
                            valid_o <= 1'b0;
                        end
                        prog_cntr_o <= prog_cntr_o + 1'b1;
                        arith_cmd_o <= arith_cmd_t'(line_i[CMD_LSB +: CMD_W]);
                    end
                endcase
            end
        end
    end

    // a multiply in flight must finish before the next line issues
    a_no_cmd_while_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (arith_cmd_o != ARITH_NONE) |-> !arith_busy_i);

endmodule

`default_nettype wire

//--- src/dsa_sequencer_rom.sv
`default_nettype none

module dsa_sequencer_rom (
    input  wire                      clk,
    input  wire dsa_ctrl_pkg::prog_addr_t addr_i,
    output dsa_ctrl_pkg::instr_t     line_o
);
    import dsa_ctrl_pkg::*;

    function automatic instr_t ucode(uop_t uop, arith_cmd_t cmd, reg_id_t id,
                                     logic [SLOT_W-1:0] slot);
        return {uop, cmd, id, slot};
    endfunction

    always_ff @(posedge clk) begin
        case (addr_i)
            // ------------------------------------------------------------
            // reset: clear the three working slots
            // ------------------------------------------------------------
            DSA_RESET: line_o <= ucode(UOP_WR_CORE, ARITH_NONE, ID_ZERO, 3'd0);
            6'd1:      line_o <= ucode(UOP_WR_CORE, ARITH_NONE, ID_ZERO, 3'd1);
            6'd2:      line_o <= ucode(UOP_WR_CORE, ARITH_NONE, ID_ZERO, 3'd2);

            // keygen: pubkey = privkey * G
            DSA_KG_S:  line_o <= ucode(UOP_WR_CORE, ARITH_NONE, ID_PRIVKEY, 3'd0);
            6'd5:      line_o <= ucode(UOP_WR_CORE, ARITH_MUL, ID_GEN, 3'd1);
            DSA_KG_E:  line_o <= ucode(UOP_RD_CORE, ARITH_NONE, ID_PUBKEY, 3'd2);

            // ------------------------------------------------------------
            // sign: s = msg + r * privkey
            // ------------------------------------------------------------
            DSA_SGN_S: line_o <= ucode(UOP_WR_CORE, ARITH_NONE, ID_R, 3'd0);
            6'd9:      line_o <= ucode(UOP_WR_CORE, ARITH_MUL, ID_PRIVKEY, 3'd1);
            6'd11:     line_o <= ucode(UOP_RD_CORE, ARITH_NONE, ID_TMP, 3'd2);
            6'd12:     line_o <= ucode(UOP_WR_CORE, ARITH_NONE, ID_MSG, 3'd0);
            6'd13:     line_o <= ucode(UOP_WR_CORE, ARITH_ADD, ID_TMP, 3'd1);
            DSA_SGN_E: line_o <= ucode(UOP_RD_CORE, ARITH_NONE, ID_SIGN_S, 3'd2);

            // verify: msg = s - r * privkey
            DSA_VER_S: line_o <= ucode(UOP_WR_CORE, ARITH_NONE, ID_R, 3'd0);
            6'd16:     line_o <= ucode(UOP_WR_CORE, ARITH_MUL, ID_PRIVKEY, 3'd1);
            6'd18:     line_o <= ucode(UOP_RD_CORE, ARITH_NONE, ID_TMP, 3'd2);
            6'd19:     line_o <= ucode(UOP_WR_CORE, ARITH_NONE, ID_S, 3'd0);
            6'd20:     line_o <= ucode(UOP_WR_CORE, ARITH_SUB, ID_TMP, 3'd1);
            DSA_VER_E: line_o <= ucode(UOP_RD_CORE, ARITH_NONE, ID_VERIFY, 3'd2);

            // idle line and the lines held during a multiply stall
            default:   line_o <= ucode(UOP_NOP, ARITH_NONE, ID_ZERO, 3'd0);
        endcase
    end

endmodule

`default_nettype wire

//--- src/ecc_dsa_ctrl.sv
`default_nettype none

module ecc_dsa_ctrl (
    input  wire                          clk,
    input  wire                          reset_n,
    input  wire dsa_ctrl_pkg::dsa_cmd_t  cmd_i,
    input  wire dsa_ctrl_pkg::word_t     msg_i,
    input  wire dsa_ctrl_pkg::word_t     privkey_i,
    input  wire dsa_ctrl_pkg::word_t     r_i,
    input  wire dsa_ctrl_pkg::word_t     s_i,
    output wire dsa_ctrl_pkg::word_t     pubkey_o,
    output wire dsa_ctrl_pkg::word_t     sign_s_o,
    output wire dsa_ctrl_pkg::word_t     verify_o,
    output wire                          ready_o,
    output wire                          valid_o
);
    import dsa_ctrl_pkg::*;

    prog_addr_t prog_cntr;
    instr_t     prog_line;
    arith_cmd_t arith_cmd;
    logic       arith_busy;
    word_t      write_data;
    word_t      read_data;

    dsa_sequencer_rom dsa_sequencer_rom_inst (
        .clk    (clk),
        .addr_i (prog_cntr),
        .line_o (prog_line)
    );

    dsa_prog_ctrl dsa_prog_ctrl_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_i        (cmd_i),
        .line_i       (prog_line),
        .arith_busy_i (arith_busy),
        .prog_cntr_o  (prog_cntr),
        .arith_cmd_o  (arith_cmd),
        .ready_o      (ready_o),
        .valid_o      (valid_o)
    );

    dsa_operand_router dsa_operand_router_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .ready_i      (ready_o),
        .line_i       (prog_line),
        .msg_i        (msg_i),
        .privkey_i    (privkey_i),
        .r_i          (r_i),
        .s_i          (s_i),
        .read_data_i  (read_data),
        .write_data_o (write_data),
        .pubkey_o     (pubkey_o),
        .sign_s_o     (sign_s_o),
        .verify_o     (verify_o)
    );

    mod_arith_unit mod_arith_unit_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .line_i       (prog_line),
        .arith_cmd_i  (arith_cmd),
        .write_data_i (write_data),
        .read_data_o  (read_data),
        .busy_o       (arith_busy)
    );

endmodule

`default_nettype wire

//--- src/mod_arith_unit.sv
`default_nettype none

module mod_arith_unit (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire dsa_ctrl_pkg::instr_t     line_i,
    input  wire dsa_ctrl_pkg::arith_cmd_t arith_cmd_i,
    input  wire dsa_ctrl_pkg::word_t      write_data_i,
    output dsa_ctrl_pkg::word_t           read_data_o,
    output logic                          busy_o
);
    import dsa_ctrl_pkg::*;

    localparam int SLOTS = 2 ** SLOT_W;
    localparam int MUL_W = $clog2(DATA_W);
    localparam logic [MUL_W-1:0] MUL_LAST = MUL_W'(DATA_W - 1);

    word_t             slot [SLOTS];
    logic [SLOT_W-1:0] slot_addr;
    uop_t              uop;
    word_t             acc;
    word_t             mcand;
    word_t             mplier;
    word_t             acc_dbl;
    word_t             acc_next;
    logic [MUL_W-1:0]  mul_cnt;

    // a + b mod P, both operands already below P
    function automatic word_t mod_add(word_t a, word_t b);
        logic [DATA_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, PRIME}) s = s - {1'b0, PRIME};
        return s[DATA_W-1:0];
    endfunction

    function automatic word_t mod_sub(word_t a, word_t b);
        logic [DATA_W:0] d;
        d = {1'b0, a} - {1'b0, b};
        if (d[DATA_W]) d = d + {1'b0, PRIME};
        return d[DATA_W-1:0];
    endfunction

    assign uop         = uop_t'(line_i[UOP_LSB +: UOP_W]);
    assign slot_addr   = line_i[SLOT_LSB +: SLOT_W];
    assign read_data_o = slot[slot_addr];

    // ------------------------------------------------------------
    // shift-add multiply, multiplier msb first
    // ------------------------------------------------------------
    assign acc_dbl  = mod_add(acc, acc);
    assign acc_next = mplier[DATA_W-1] ? mod_add(acc_dbl, mcand) : acc_dbl;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_o  <= 1'b0;
            mul_cnt <= '0;
        end else if (busy_o) begin
            mul_cnt <= mul_cnt + 1'b1;
            if (mul_cnt == MUL_LAST) busy_o <= 1'b0;
        end else if (arith_cmd_i == ARITH_MUL) begin
            busy_o  <= 1'b1;
            mul_cnt <= '0;
        end
    end

    // slot file and multiply datapath
    always_ff @(posedge clk) begin
        if (uop == UOP_WR_CORE) begin
            slot[slot_addr] <= write_data_i;
        end
        if (busy_o) begin
            acc    <= acc_next;
            mplier <= mplier << 1;
            if (mul_cnt == MUL_LAST) slot[2] <= acc_next;
        end else begin
            case (arith_cmd_i)
                ARITH_ADD: slot[2] <= mod_add(slot[0], slot[1]);
                ARITH_SUB: slot[2] <= mod_sub(slot[0], slot[1]);
                ARITH_MUL: begin
                    acc    <= '0;
                    mcand  <= slot[0];
                    mplier <= slot[1];
                end
                default:   ;
            endcase
        end
    end

    a_result_reduced: assert property (@(posedge clk) disable iff (!reset_n)
        ((!busy_o && arith_cmd_i inside {ARITH_ADD, ARITH_SUB})
         || (busy_o && mul_cnt == MUL_LAST)) |=> (slot[2] < PRIME));

endmodule

`default_nettype wire

//--- verilog.f
src/dsa_ctrl_pkg.sv
src/dsa_sequencer_rom.sv
src/dsa_prog_ctrl.sv
src/dsa_operand_router.sv
src/mod_arith_unit.sv
src/ecc_dsa_ctrl.sv
sim/tb_ecc_dsa_ctrl.sv
